// File: verilog.f
logger_pkg.sv
lib_pipe.sv
twowayhandshake_logger.sv
axichannel_logger.sv
log_entry_writer.sv
log_fifo.sv
channel_log_top.sv
tb_channel_log.sv

// File: run_sim.sh
#!/bin/sh
# build and run the channel logger testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_channel_log \
  -f verilog.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation PASSED"
exit 0

// File: tb_channel_log.sv
`timescale 1ns/1ps
`default_nettype none

module tb_channel_log;

  // test lengths
  localparam int TOTAL_WORDS = 300;
  localparam int RANDOM_WORDS = 240;
  localparam int STALL_CYCLES = 64;
  localparam int STALL_SETTLE = 40;
  localparam int DRAIN_LEN = 200;
  localparam int TIMEOUT_CYCLES = 4 * (TOTAL_WORDS + DRAIN_LEN);
  localparam int READY_LIMIT = 2 * logger_pkg::PIPE_DEPTH + 4;

  logic                              clk;
  logic                              rstn;
  logic                              in_valid;
  logic                              in_ready;
  logic [logger_pkg::DATA_WIDTH-1:0] in_data;
  logic                              out_valid;
  logic                              out_ready;
  logic [logger_pkg::DATA_WIDTH-1:0] out_data;
  logic                              log_pop;
  logic                              log_empty;
  logger_pkg::log_entry_u            log_entry;

  // stimulus words and scoreboard state
  logic [logger_pkg::DATA_WIDTH-1:0] words [TOTAL_WORDS];
  logic [logger_pkg::DATA_WIDTH-1:0] exp_out [$];
  logic [logger_pkg::DATA_WIDTH-1:0] got_out [$];
  logger_pkg::log_entry_u            exp_log [$];
  logger_pkg::log_entry_u            got_log [$];
  int n_in;
  int n_out;
  int n_pop;
  int begin_seq;
  int end_seq;
  int wait_cur;
  int cycle_cnt;
  logic stall_check;

  channel_log_top DUT (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .log_pop  (log_pop),
    .log_empty(log_empty),
    .log_entry(log_entry)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // failure handling and compares
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [logger_pkg::DATA_WIDTH-1:0] got,
                            input logic [logger_pkg::DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: time %0t, signal %s, got %h, expected %h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_entry(input string name, input logger_pkg::log_entry_u got,
                             input logger_pkg::log_entry_u exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: time %0t, signal %s, got %h, expected %h",
                          $time, name, got, exp));
    end
  endtask

  // reference model for the entries of one edge
  // end of the older word goes before the new begin
  function automatic void expected_entries(input logic out_xfer, input int wait_val,
                                           input logic in_xfer,
                                           input logic [logger_pkg::DATA_WIDTH-1:0] data);
    logger_pkg::log_entry_u e;
    if (out_xfer) begin
      e = {logger_pkg::KIND_END, logger_pkg::SEQ_WIDTH'(end_seq),
           logger_pkg::WAIT_WIDTH'(wait_val)};
      exp_log.push_back(e);
      end_seq++;
    end
    if (in_xfer) begin
      e = {logger_pkg::KIND_BEGIN, logger_pkg::SEQ_WIDTH'(begin_seq), data};
      exp_log.push_back(e);
      begin_seq++;
    end
  endfunction

  //////////////////////////////////////////////////
  // monitor samples mid-cycle where all is stable
  //////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic in_xfer;
    logic out_xfer;
    if (rstn == 1'b0) begin
      in_xfer  = in_valid && in_ready;
      out_xfer = out_valid && out_ready;
      if (out_xfer) begin
        got_out.push_back(out_data);
        n_out++;
      end
      expected_entries(out_xfer, wait_cur, in_xfer, in_data);
      // stall cycles of the word now on the output
      if (out_valid && !out_ready && wait_cur < 65535) begin
        wait_cur++;
      end
      if (in_xfer) begin
        $display("accepted word %0d: %h", n_in, in_data);
        exp_out.push_back(in_data);
        n_in++;
        wait_cur = 0;
      end
      if (log_pop && !log_empty) begin
        got_log.push_back(log_entry);
        n_pop++;
      end
      if (stall_check && in_ready) begin
        abort_run("in_ready went high while the log was held full");
      end
    end
  end

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////

  int n_begin_seen;
  int n_end_seen;

  always @(posedge clk) begin : compare
    logger_pkg::log_entry_u got_e;
    while (got_out.size() > 0) begin
      if (exp_out.size() == 0) begin
        abort_run("output transfer with no accepted word pending");
      end else begin
        check_data("out_data", got_out.pop_front(), exp_out.pop_front());
      end
    end
    while (got_log.size() > 0) begin
      got_e = got_log.pop_front();
      if (exp_log.size() == 0) begin
        abort_run("log entry popped when none was expected");
      end else begin
        if (got_e.as_end.kind == logger_pkg::KIND_END) begin
          // an end must never overtake the begin of its word
          if (n_begin_seen <= n_end_seen) begin
            abort_run("end entry popped before the begin entry of its word");
          end
          n_end_seen++;
        end else begin
          n_begin_seen++;
        end
        check_entry("log_entry", got_e, exp_log.pop_front());
      end
    end
  end

  // hang guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic drive_random(input int pop_pct);
    @(posedge clk);
    #1;
    in_valid  = (n_in < TOTAL_WORDS) && (($urandom % 4) != 0);
    in_data   = (n_in < TOTAL_WORDS) ? words[n_in] : '0;
    out_ready = ($urandom % 10) < 7;
    log_pop   = ($urandom % 100) < pop_pct;
  endtask

  initial begin : stimulus
    int wait_ready;
    void'($urandom(97));
    rstn = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    log_pop = 1'b0;
    stall_check = 1'b0;
    for (int i = 0; i < TOTAL_WORDS; i++) begin
      words[i] = logger_pkg::DATA_WIDTH'($urandom);
    end
    repeat (3) @(posedge clk);
    #1 rstn = 1'b0;

    // reset state and input opening on its own
    @(negedge clk);
    if (out_valid !== 1'b0) abort_run("out_valid is not low after reset");
    if (log_empty !== 1'b1) abort_run("log_empty is not high after reset");
    wait_ready = 0;
    while (in_ready !== 1'b1) begin
      @(negedge clk);
      wait_ready++;
      if (wait_ready > READY_LIMIT) abort_run("in_ready did not rise after reset");
    end

    // random pass-through with random popping
    while (n_in < RANDOM_WORDS) begin
      drive_random(80);
    end

    // log held unpopped so the input must stall
    for (int i = 0; i < STALL_CYCLES; i++) begin
      @(posedge clk);
      #1;
      in_valid    = n_in < TOTAL_WORDS;
      in_data     = (n_in < TOTAL_WORDS) ? words[n_in] : '0;
      out_ready   = 1'b1;
      log_pop     = 1'b0;
      stall_check = (i >= STALL_SETTLE);
    end
    @(posedge clk);
    #1 stall_check = 1'b0;

    // popping resumes for the rest of the words
    while (n_in < TOTAL_WORDS) begin
      drive_random(80);
    end

    // drain channel and log
    while (n_out < TOTAL_WORDS || n_pop < 2 * TOTAL_WORDS) begin
      @(posedge clk);
      #1;
      in_valid  = 1'b0;
      out_ready = 1'b1;
      log_pop   = 1'b1;
    end
    @(posedge clk);
    #1 log_pop = 1'b0;
    @(negedge clk);
    if (exp_out.size() != 0) abort_run("accepted words never left the output");
    if (exp_log.size() != 0) abort_run("expected log entries never arrived");
    if (log_empty !== 1'b1) abort_run("log holds extra entries after the drain");

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: channel_log_top.sv
`timescale 1ns/1ps
`default_nettype none

module channel_log_top (
  input  wire                               clk,
  input  wire                               rstn,
  // channel in
  input  wire                               in_valid,
  output logic                              in_ready,
  input  wire  [logger_pkg::DATA_WIDTH-1:0] in_data,
  // channel out
  output logic                              out_valid,
  input  wire                               out_ready,
  output logic [logger_pkg::DATA_WIDTH-1:0] out_data,
  // log read port
  input  wire                               log_pop,
  output logic                              log_empty,
  output logger_pkg::log_entry_u            log_entry
);

  // storage side of the event pipes
  logic                              logb_valid;
  logic [logger_pkg::DATA_WIDTH-1:0] logb_data;
  logic                              loge_valid;
  logic [logger_pkg::WAIT_WIDTH-1:0] loge_wait;
  // back to the logger, delayed there
  logic                              log_almful;
  // writer to fifo
  logic                              wr0_en;
  logger_pkg::log_entry_u            wr0_entry;
  logic                              wr1_en;
  logger_pkg::log_entry_u            wr1_entry;

  axichannel_logger chan_logger (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .logb_valid (logb_valid),
    .logb_data  (logb_data),
    .loge_valid (loge_valid),
    .loge_wait  (loge_wait),
    .logb_almful(log_almful)
  );

  // one cycle to pack, one more to land in the fifo
  log_entry_writer writer (
    .clk       (clk),
    .rstn      (rstn),
    .logb_valid(logb_valid),
    .logb_data (logb_data),
    .loge_valid(loge_valid),
    .loge_wait (loge_wait),
    .wr0_en    (wr0_en),
    .wr0_entry (wr0_entry),
    .wr1_en    (wr1_en),
    .wr1_entry (wr1_entry)
  );

  log_fifo fifo (
    .clk       (clk),
    .rstn      (rstn),
    .wr0_en    (wr0_en),
    .wr0_entry (wr0_entry),
    .wr1_en    (wr1_en),
    .wr1_entry (wr1_entry),
    .log_pop   (log_pop),
    .log_empty (log_empty),
    .log_entry (log_entry),
    .log_almful(log_almful)
  );

endmodule

`default_nettype wire

// File: log_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module log_fifo (
  input  wire                    clk,
  input  wire                    rstn,
  // port 0 written ahead of port 1 on the same edge
  input  wire                    wr0_en,
  input  wire logger_pkg::log_entry_u wr0_entry,
  input  wire                    wr1_en,
  input  wire logger_pkg::log_entry_u wr1_entry,
  // read side, first-word fall-through
  input  wire                    log_pop,
  output logic                   log_empty,
  output logger_pkg::log_entry_u log_entry,
  output logic                   log_almful
);

  // entry storage, no reset
  logger_pkg::log_entry_u mem [logger_pkg::FIFO_DEPTH];

  logic [logger_pkg::PTR_WIDTH-1:0] wr_ptr_q;
  logic [logger_pkg::PTR_WIDTH-1:0] rd_ptr_q;
  logic [logger_pkg::CNT_WIDTH-1:0] count_q;
  logic [logger_pkg::CNT_WIDTH-1:0] count_next;
  logic [logger_pkg::CNT_WIDTH-1:0] free_next;
  logic [1:0]                       n_wr;
  logic                             do_pop;

  //////////////////////////////////////////////////
  // bookkeeping
  //////////////////////////////////////////////////

  // zero, one or two writes this edge
  assign n_wr = {1'b0, wr0_en} + {1'b0, wr1_en};
  // pop on empty ignored
  assign do_pop = log_pop && !log_empty;

  assign count_next = count_q + logger_pkg::CNT_WIDTH'(n_wr)
                    - logger_pkg::CNT_WIDTH'(do_pop);
  assign free_next = logger_pkg::CNT_WIDTH'(logger_pkg::FIFO_DEPTH) - count_next;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      log_almful <= 1'b0;
    end else begin
      // pointers wrap, depth is a power of two
      wr_ptr_q <= wr_ptr_q + logger_pkg::PTR_WIDTH'(n_wr);
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_next;
      // registered compare of next free count
      log_almful <= free_next < logger_pkg::CNT_WIDTH'(logger_pkg::ALMFUL_FREE);
    end
  end

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // port 1 goes one slot past port 0 when both write
  always_ff @(posedge clk) begin
    if (wr0_en) begin
      mem[wr_ptr_q] <= wr0_entry;
    end
    if (wr1_en) begin
      mem[wr_ptr_q + logger_pkg::PTR_WIDTH'(wr0_en)] <= wr1_entry;
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  // oldest entry shown directly, valid the cycle after its write
  assign log_empty = (count_q == '0);
  assign log_entry = mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: log_entry_writer.sv
`timescale 1ns/1ps
`default_nettype none

module log_entry_writer (
  input  wire                               clk,
  input  wire                               rstn,
  input  wire                               logb_valid,
  input  wire  [logger_pkg::DATA_WIDTH-1:0] logb_data,
  input  wire                               loge_valid,
  input  wire  [logger_pkg::WAIT_WIDTH-1:0] loge_wait,
  // write port 0 always takes the older event
  output logic                              wr0_en,
  output logger_pkg::log_entry_u            wr0_entry,
  output logic                              wr1_en,
  output logger_pkg::log_entry_u            wr1_entry
);

  logic [logger_pkg::SEQ_WIDTH-1:0] begin_seq_q;
  logic [logger_pkg::SEQ_WIDTH-1:0] end_seq_q;
  logger_pkg::log_entry_u           begin_word;
  logger_pkg::log_entry_u           end_word;

  // separate counters, wrap naturally at 2^15
  always_ff @(posedge clk) begin
    if (rstn) begin
      begin_seq_q <= '0;
      end_seq_q   <= '0;
    end else begin
      if (logb_valid) begin
        begin_seq_q <= begin_seq_q + 1'b1;
      end
      if (loge_valid) begin
        end_seq_q <= end_seq_q + 1'b1;
      end
    end
  end

  // pack each event through its own view of the union
  always_comb begin
    begin_word.as_begin.kind = logger_pkg::KIND_BEGIN;
    begin_word.as_begin.seq  = begin_seq_q;
    begin_word.as_begin.data = logb_data;
  end

  always_comb begin
    end_word.as_end.kind     = logger_pkg::KIND_END;
    end_word.as_end.seq      = end_seq_q;
    end_word.as_end.wait_cnt = loge_wait;
  end

  //////////////////////////////////////////////////
  // port ordering
  //////////////////////////////////////////////////

  // same-cycle pair: end belongs to the older word, goes first
  always_ff @(posedge clk) begin
    if (rstn) begin
      wr0_en <= 1'b0;
      wr1_en <= 1'b0;
    end else begin
      wr0_en <= logb_valid || loge_valid;
      wr1_en <= logb_valid && loge_valid;
    end
  end

  // begin lands on port 1 only when paired
  always_ff @(posedge clk) begin
    wr0_entry <= loge_valid ? end_word : begin_word;
    wr1_entry <= begin_word;
  end

endmodule

`default_nettype wire

// File: axichannel_logger.sv
`timescale 1ns/1ps
`default_nettype none

module axichannel_logger (
  input  wire                               clk,
  input  wire                               rstn,
  input  wire                               in_valid,
  output logic                              in_ready,
  input  wire  [logger_pkg::DATA_WIDTH-1:0] in_data,
  output logic                              out_valid,
  input  wire                               out_ready,
  output logic [logger_pkg::DATA_WIDTH-1:0] out_data,
  // storage side of the pipelines
  output logic                              logb_valid,
  output logic [logger_pkg::DATA_WIDTH-1:0] logb_data,
  output logic                              loge_valid,
  output logic [logger_pkg::WAIT_WIDTH-1:0] loge_wait,
  // almost-full straight from the fifo
  input  wire                               logb_almful
);

  // _p signals sit on the logger side of the pipes
  logic                              logb_valid_p;
  logic [logger_pkg::DATA_WIDTH-1:0] logb_data_p;
  logic                              loge_valid_p;
  logic [logger_pkg::WAIT_WIDTH-1:0] loge_wait_p;
  logic                              logb_almful_p;

  // begin held off by delayed almost-full
  // end always has room, slack covered by ALMFUL_FREE
  twowayhandshake_logger logger (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .logb_valid(logb_valid_p),
    .logb_ready(!logb_almful_p),
    .logb_data (logb_data_p),
    .loge_valid(loge_valid_p),
    .loge_wait (loge_wait_p)
  );

  //////////////////////////////////////////////////
  // forward pipes, one per signal
  //////////////////////////////////////////////////

  lib_pipe #(.WIDTH(1), .STAGES(logger_pkg::PIPE_DEPTH)) logb_valid_pipe (
    .clk(clk), .rstn(rstn), .in_bus(logb_valid_p), .out_bus(logb_valid)
  );

  lib_pipe #(.WIDTH(logger_pkg::DATA_WIDTH), .STAGES(logger_pkg::PIPE_DEPTH)) logb_data_pipe (
    .clk(clk), .rstn(rstn), .in_bus(logb_data_p), .out_bus(logb_data)
  );

  lib_pipe #(.WIDTH(1), .STAGES(logger_pkg::PIPE_DEPTH)) loge_valid_pipe (
    .clk(clk), .rstn(rstn), .in_bus(loge_valid_p), .out_bus(loge_valid)
  );

  lib_pipe #(.WIDTH(logger_pkg::WAIT_WIDTH), .STAGES(logger_pkg::PIPE_DEPTH)) loge_wait_pipe (
    .clk(clk), .rstn(rstn), .in_bus(loge_wait_p), .out_bus(loge_wait)
  );

  //////////////////////////////////////////////////
  // feedback pipe
  //////////////////////////////////////////////////

  // resets low, so input opens once this clears
  lib_pipe #(.WIDTH(1), .STAGES(logger_pkg::PIPE_DEPTH)) logb_almful_pipe (
    .clk(clk), .rstn(rstn), .in_bus(logb_almful), .out_bus(logb_almful_p)
  );

endmodule

`default_nettype wire

// File: twowayhandshake_logger.sv
`timescale 1ns/1ps
`default_nettype none

module twowayhandshake_logger (
  input  wire                               clk,
  input  wire                               rstn,
  // input side of the channel
  input  wire                               in_valid,
  output logic                              in_ready,
  input  wire  [logger_pkg::DATA_WIDTH-1:0] in_data,
  // output side of the channel
  output logic                              out_valid,
  input  wire                               out_ready,
  output logic [logger_pkg::DATA_WIDTH-1:0] out_data,
  // begin events, held off by logb_ready
  output logic                              logb_valid,
  input  wire                               logb_ready,
  output logic [logger_pkg::DATA_WIDTH-1:0] logb_data,
  // end events, never held off
  output logic                              loge_valid,
  output logic [logger_pkg::WAIT_WIDTH-1:0] loge_wait
);

  logic                              in_fire;
  logic                              out_fire;
  logic [logger_pkg::WAIT_WIDTH-1:0] wait_cnt_q;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // slot free or draining this cycle, and log has room
  assign in_ready = (!out_valid || out_ready) && logb_ready;
  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  // one-entry holding register
  // a fill and a drain on the same edge reload with no bubble
  always_ff @(posedge clk) begin
    if (rstn) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_fire) begin
      out_valid <= 1'b0;
    end
  end

  // word stays put while the output stalls
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_data <= in_data;
    end
  end

  //////////////////////////////////////////////////
  // stall counter
  //////////////////////////////////////////////////

  // counts cycles this word sat on the output unaccepted
  always_ff @(posedge clk) begin
    if (rstn) begin
      wait_cnt_q <= '0;
    end else if (in_fire) begin
      // fresh word starts at zero
      wait_cnt_q <= '0;
    end else if (out_valid && !out_ready && (wait_cnt_q != '1)) begin
      // saturates at all ones
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // event pulses
  //////////////////////////////////////////////////

  // begin and end are one-cycle pulses the cycle after the transfer
  always_ff @(posedge clk) begin
    if (rstn) begin
      logb_valid <= 1'b0;
      loge_valid <= 1'b0;
    end else begin
      logb_valid <= in_fire;
      loge_valid <= out_fire;
    end
  end

  // payload of the pulses
  always_ff @(posedge clk) begin
    if (in_fire) begin
      logb_data <= in_data;
    end
    // count is final here, out_ready is high on the fire cycle
    if (out_fire) begin
      loge_wait <= wait_cnt_q;
    end
  end

endmodule

`default_nettype wire

// File: lib_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lib_pipe #(
  parameter int unsigned WIDTH = 1,
  parameter int unsigned STAGES = 1
) (
  input  wire              clk,
  input  wire              rstn,
  input  wire  [WIDTH-1:0] in_bus,
  output logic [WIDTH-1:0] out_bus
);

  // one register per stage, index 0 is nearest the input
  logic [WIDTH-1:0] stage_q [STAGES];

  // plain shift chain
  // all stages cleared so no stale pulse leaks out after reset
  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in_bus;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // last stage drives the output
  assign out_bus = stage_q[STAGES-1];

endmodule

`default_nettype wire

// File: logger_pkg.sv
`default_nettype none

package logger_pkg;

  //////////////////////////////////////////////////
  // channel and pipeline sizing
  //////////////////////////////////////////////////

  // width of one channel word
  localparam int unsigned DATA_WIDTH = 16;
  // register stages per log pipeline
  localparam int unsigned PIPE_DEPTH = 4;
  // sequence number field, wraps at 2^15
  localparam int unsigned SEQ_WIDTH = 15;
  // saturating wait count
  localparam int unsigned WAIT_WIDTH = 16;
  localparam int unsigned LOG_WIDTH = 32;

  //////////////////////////////////////////////////
  // log fifo sizing
  //////////////////////////////////////////////////

  localparam int unsigned FIFO_DEPTH = 64;
  localparam int unsigned PTR_WIDTH = $clog2(FIFO_DEPTH);
  // occupancy needs one more bit to hold a full count
  localparam int unsigned CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
  // feedback loop is ~2*PIPE_DEPTH+2 cycles at two writes each
  localparam int unsigned ALMFUL_FREE = 4 * PIPE_DEPTH + 4;

  // kind field values
  localparam logic KIND_BEGIN = 1'b0;
  localparam logic KIND_END = 1'b1;

  //////////////////////////////////////////////////
  // log entry layouts
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                  kind;
    logic [SEQ_WIDTH-1:0]  seq;
    logic [DATA_WIDTH-1:0] data;
  } log_begin_t;

  typedef struct packed {
    logic                  kind;
    logic [SEQ_WIDTH-1:0]  seq;
    logic [WAIT_WIDTH-1:0] wait_cnt;
  } log_end_t;

  // one 32-bit word, decoded by its kind bit
  typedef union packed {
    log_begin_t as_begin;
    log_end_t   as_end;
  } log_entry_u;

endpackage

`default_nettype wire
